//--- build.f
+incdir+source
source/aib_avmm_pkg.sv
source/aib_avmm_rdl_intf.sv
source/aib_avmm_adapt_csr.sv
source/aib_avmm_aibio_csr.sv
source/aib_avmm_rsp_merge.sv
source/aib_avmm.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_aib_avmm.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_aib_avmm

./obj_dir/Vtb_aib_avmm > sim.log 2>&1
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1

//--- source/aib_avmm.sv
`timescale 1ns/1ps

module aib_avmm
  import aib_avmm_pkg::*;
(
  input  logic        cfg_avmm_clk,
  input  logic        rst_n,
  input  logic [5:0]  cfg_avmm_addr_id,
  input  logic        cfg_avmm_write,
  input  logic        cfg_avmm_read,
  input  logic [16:0] cfg_avmm_addr,
  input  logic [31:0] cfg_avmm_wdata,
  input  logic [3:0]  cfg_avmm_byte_en,
  output logic [31:0] cfg_avmm_rdata,
  output logic        cfg_avmm_rdatavld,
  output logic        cfg_avmm_waitreq,
  output adapt_cfg_t  adapt_cfg,        // rx/tx adapt words
  output aibio_cfg_t  aibio_cfg,        // if ctrl, rst override, outbox
  input  logic [31:0] inbox_msg,
  input  logic        inbox_load,
  output logic        outbox_send,
  output logic        inbox_new_msg
);

  csr_req_t csr_req;   // shared by both banks
  csr_rsp_t adapt_rsp;
  csr_rsp_t aibio_rsp;

  aib_avmm_rdl_intf rdl_intf (
    .cfg_avmm_clk     (cfg_avmm_clk),
    .rst_n            (rst_n),
    .cfg_avmm_addr_id (cfg_avmm_addr_id),
    .cfg_avmm_write   (cfg_avmm_write),
    .cfg_avmm_read    (cfg_avmm_read),
    .cfg_avmm_addr    (cfg_avmm_addr),
    .cfg_avmm_wdata   (cfg_avmm_wdata),
    .cfg_avmm_byte_en (cfg_avmm_byte_en),
    .cfg_avmm_waitreq (cfg_avmm_waitreq),
    .csr_req          (csr_req)
  );

  aib_avmm_adapt_csr adapt_csr (
    .cfg_avmm_clk (cfg_avmm_clk),
    .rst_n        (rst_n),
    .csr_req      (csr_req),
    .csr_rsp      (adapt_rsp),
    .adapt_cfg    (adapt_cfg)
  );

  aib_avmm_aibio_csr aibio_csr (
    .cfg_avmm_clk  (cfg_avmm_clk),
    .rst_n         (rst_n),
    .csr_req       (csr_req),
    .csr_rsp       (aibio_rsp),
    .inbox_msg     (inbox_msg),
    .inbox_load    (inbox_load),
    .aibio_cfg     (aibio_cfg),
    .outbox_send   (outbox_send),
    .inbox_new_msg (inbox_new_msg)
  );

  aib_avmm_rsp_merge rsp_merge (
    .cfg_avmm_clk      (cfg_avmm_clk),
    .rst_n             (rst_n),
    .adapt_rsp         (adapt_rsp),
    .aibio_rsp         (aibio_rsp),
    .cfg_avmm_rdata    (cfg_avmm_rdata),
    .cfg_avmm_rdatavld (cfg_avmm_rdatavld)
  );

endmodule

//--- source/aib_avmm_adapt_csr.sv
`timescale 1ns/1ps
`include "aib_avmm_defs.svh"

module aib_avmm_adapt_csr
  import aib_avmm_pkg::*;
(
  input  logic       cfg_avmm_clk,
  input  logic       rst_n,
  input  csr_req_t   csr_req,
  output csr_rsp_t   csr_rsp,
  output adapt_cfg_t adapt_cfg
);

  adapt_cfg_t  cfg_q;
  logic        hit;
  logic [31:0] rd_mux;
  logic        rsp_valid_q;
  logic        rsp_hit_q;
  logic [31:0] rsp_data_q;

  assign hit = (csr_req.addr <= `ADAPT_TX1_IDX); // rx0 is word 0

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////
  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '{rx_0: `ADAPT_RST_VAL, rx_1: `ADAPT_RST_VAL,
                 tx_0: `ADAPT_RST_VAL, tx_1: `ADAPT_RST_VAL};
    end else if (csr_req.write) begin
      case (csr_req.addr)
        `ADAPT_RX0_IDX: cfg_q.rx_0 <= be_merge(cfg_q.rx_0, csr_req.wdata, csr_req.byte_en);
        `ADAPT_RX1_IDX: cfg_q.rx_1 <= be_merge(cfg_q.rx_1, csr_req.wdata, csr_req.byte_en);
        `ADAPT_TX0_IDX: cfg_q.tx_0 <= be_merge(cfg_q.tx_0, csr_req.wdata, csr_req.byte_en);
        `ADAPT_TX1_IDX: cfg_q.tx_1 <= be_merge(cfg_q.tx_1, csr_req.wdata, csr_req.byte_en);
        default: ; // other bank or unmapped
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////
  always_comb begin
    case (csr_req.addr)
      `ADAPT_RX0_IDX: rd_mux = cfg_q.rx_0;
      `ADAPT_RX1_IDX: rd_mux = cfg_q.rx_1;
      `ADAPT_TX0_IDX: rd_mux = cfg_q.tx_0;
      `ADAPT_TX1_IDX: rd_mux = cfg_q.tx_1;
      default:        rd_mux = '0; // miss reads as zero
    endcase
  end

  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      rsp_hit_q   <= 1'b0;
    end else begin
      rsp_valid_q <= csr_req.read;
      rsp_hit_q   <= csr_req.read & hit;
    end
  end

  always_ff @(posedge cfg_avmm_clk) begin
    if (csr_req.read) rsp_data_q <= rd_mux; // only sampled with valid
  end

  assign csr_rsp   = '{valid: rsp_valid_q, hit: rsp_hit_q, data: rsp_data_q};
  assign adapt_cfg = cfg_q;

endmodule

//--- source/aib_avmm_aibio_csr.sv
`timescale 1ns/1ps
`include "aib_avmm_defs.svh"

module aib_avmm_aibio_csr
  import aib_avmm_pkg::*;
(
  input  logic        cfg_avmm_clk,
  input  logic        rst_n,
  input  csr_req_t    csr_req,
  output csr_rsp_t    csr_rsp,
  input  logic [31:0] inbox_msg,      // from far side
  input  logic        inbox_load,     // capture strobe
  output aibio_cfg_t  aibio_cfg,
  output logic        outbox_send,    // one cycle per send
  output logic        inbox_new_msg
);

  logic [31:0] ifctl_q;
  logic [31:0] rstctl_q;
  logic [31:0] outbox_q;
  logic [31:0] inbox_q;
  logic        hit;
  logic        wr_outbox;
  logic        rd_inbox;
  logic [31:0] rd_mux;
  logic        rsp_valid_q;
  logic        rsp_hit_q;
  logic [31:0] rsp_data_q;

  assign hit = (csr_req.addr >= `IFCTL_IDX) && (csr_req.addr <= `INBOX_IDX);
  assign wr_outbox = csr_req.write && (csr_req.addr == `OUTBOX_IDX);
  assign rd_inbox  = csr_req.read && (csr_req.addr == `INBOX_IDX);

  //////////////////////////////////////////////////
  // writable words
  //////////////////////////////////////////////////
  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      ifctl_q  <= `AIBIO_RST_VAL;
      rstctl_q <= `AIBIO_RST_VAL;
      outbox_q <= `AIBIO_RST_VAL;
    end else if (csr_req.write) begin
      case (csr_req.addr)
        `IFCTL_IDX:  ifctl_q  <= be_merge(ifctl_q, csr_req.wdata, csr_req.byte_en);
        `RSTCTL_IDX: rstctl_q <= be_merge(rstctl_q, csr_req.wdata, csr_req.byte_en);
        `OUTBOX_IDX: outbox_q <= be_merge(outbox_q, csr_req.wdata, csr_req.byte_en);
        default: ; // inbox is read only
      endcase
    end
  end

  //////////////////////////////////////////////////
  // message strobes
  //////////////////////////////////////////////////
  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      outbox_send   <= 1'b0;
      inbox_q       <= `AIBIO_RST_VAL;
      inbox_new_msg <= 1'b0;
    end else begin
      outbox_send <= wr_outbox; // one pulse per outbox write
      if (inbox_load) begin
        inbox_q       <= inbox_msg;
        inbox_new_msg <= 1'b1; // load wins over clear
      end else if (rd_inbox && !ifctl_q[0]) begin
        inbox_new_msg <= 1'b0; // autoclear on read
      end
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////
  always_comb begin
    case (csr_req.addr)
      `IFCTL_IDX:  rd_mux = ifctl_q;
      `RSTCTL_IDX: rd_mux = rstctl_q;
      `OUTBOX_IDX: rd_mux = outbox_q;
      `INBOX_IDX:  rd_mux = inbox_q;
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      rsp_hit_q   <= 1'b0;
    end else begin
      rsp_valid_q <= csr_req.read;
      rsp_hit_q   <= csr_req.read & hit;
    end
  end

  always_ff @(posedge cfg_avmm_clk) begin
    if (csr_req.read) rsp_data_q <= rd_mux;
  end

  assign csr_rsp   = '{valid: rsp_valid_q, hit: rsp_hit_q, data: rsp_data_q};
  assign aibio_cfg = '{ifctl: ifctl_q, rstctl: rstctl_q, outbox_msg: outbox_q,
                       inbox_autoclear_dis: ifctl_q[0]};

  // a send ends after one cycle unless another outbox write follows
  a_send_pulse: assert property (@(posedge cfg_avmm_clk) disable iff (!rst_n)
    outbox_send && !wr_outbox |=> !outbox_send);

endmodule

//--- source/aib_avmm_defs.svh
`ifndef AIB_AVMM_DEFS_SVH
`define AIB_AVMM_DEFS_SVH

//////////////////////////////////////////////////
// configuration window, byte offsets within channel
//////////////////////////////////////////////////
`define AIB_BASE_BOT    11'h200       // inclusive
`define AIB_BASE_TOP    11'h400       // exclusive

// word index = offset[8:2]
`define CSR_ADDR_W      7

//////////////////////////////////////////////////
// register word indices
//////////////////////////////////////////////////
`define ADAPT_RX0_IDX   7'd0          // rx adapt ctrl 0
`define ADAPT_RX1_IDX   7'd1          // rx adapt ctrl 1
`define ADAPT_TX0_IDX   7'd2          // tx adapt ctrl 0
`define ADAPT_TX1_IDX   7'd3          // tx adapt ctrl 1
`define IFCTL_IDX       7'd8          // interface ctrl, bit 0 = inbox autoclear dis
`define RSTCTL_IDX      7'd9          // reset override
`define OUTBOX_IDX      7'd10         // outbound message
`define INBOX_IDX       7'd11         // inbound message, read only

`define ADAPT_RST_VAL   32'h0000_0000 // adapter bank reset value
`define AIBIO_RST_VAL   32'h0000_0000 // aibio bank reset value

`endif

//--- source/aib_avmm_pkg.sv
`include "aib_avmm_defs.svh"

package aib_avmm_pkg;

  // one word request from the front end to both banks
  typedef struct packed {
    logic                   write;    // write strobe
    logic                   read;     // read strobe
    logic [`CSR_ADDR_W-1:0] addr;     // word index
    logic [31:0]            wdata;
    logic [3:0]             byte_en;
  } csr_req_t;

  // per bank read response
  typedef struct packed {
    logic        valid;               // read seen, hit or not
    logic        hit;                 // index owned by this bank
    logic [31:0] data;                // zero on miss
  } csr_rsp_t;

  typedef struct packed {
    logic [31:0] rx_0;
    logic [31:0] rx_1;
    logic [31:0] tx_0;
    logic [31:0] tx_1;
  } adapt_cfg_t;

  typedef struct packed {
    logic [31:0] ifctl;               // interface ctrl
    logic [31:0] rstctl;              // reset override val/en pairs
    logic [31:0] outbox_msg;          // message to far side
    logic        inbox_autoclear_dis; // mirrors ifctl[0]
  } aibio_cfg_t;

  // byte enable merge of a write into a held word
  function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8]; // lane i
    end
    return res;
  endfunction

endpackage

//--- source/aib_avmm_rdl_intf.sv
`timescale 1ns/1ps
`include "aib_avmm_defs.svh"

module aib_avmm_rdl_intf
  import aib_avmm_pkg::*;
(
  input  logic        cfg_avmm_clk,
  input  logic        rst_n,
  input  logic [5:0]  cfg_avmm_addr_id,   // this channel's id
  input  logic        cfg_avmm_write,
  input  logic        cfg_avmm_read,
  input  logic [16:0] cfg_avmm_addr,      // [16:11] id, [10:0] offset
  input  logic [31:0] cfg_avmm_wdata,
  input  logic [3:0]  cfg_avmm_byte_en,
  output logic        cfg_avmm_waitreq,
  output csr_req_t    csr_req
);

  logic [10:0]            offset;
  logic                   id_match;
  logic                   win_match;
  logic                   accept_wr;
  logic                   accept_rd;
  logic                   req_wr_q;
  logic                   req_rd_q;
  logic [`CSR_ADDR_W-1:0] req_addr_q;
  logic [31:0]            req_wdata_q;
  logic [3:0]             req_be_q;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  assign offset    = cfg_avmm_addr[10:0];
  assign id_match  = (cfg_avmm_addr[16:11] == cfg_avmm_addr_id);
  assign win_match = (offset >= `AIB_BASE_BOT) && (offset < `AIB_BASE_TOP);

  // misses are dropped, no response
  assign accept_wr = cfg_avmm_write & ~cfg_avmm_waitreq & id_match & win_match;
  assign accept_rd = cfg_avmm_read & ~cfg_avmm_waitreq & id_match & win_match;

  // held through reset, released on first edge after
  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) cfg_avmm_waitreq <= 1'b1;
    else        cfg_avmm_waitreq <= 1'b0;
  end

  //////////////////////////////////////////////////
  // request register
  //////////////////////////////////////////////////
  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      req_wr_q <= 1'b0;
      req_rd_q <= 1'b0;
    end else begin
      req_wr_q <= accept_wr; // one cycle strobe
      req_rd_q <= accept_rd;
    end
  end

  always_ff @(posedge cfg_avmm_clk) begin
    if (accept_wr || accept_rd) begin
      req_addr_q  <= offset[`CSR_ADDR_W+1:2]; // byte -> word
      req_wdata_q <= cfg_avmm_wdata;
      req_be_q    <= cfg_avmm_byte_en;
    end
  end

  assign csr_req = '{write: req_wr_q, read: req_rd_q, addr: req_addr_q,
                     wdata: req_wdata_q, byte_en: req_be_q};

  // an accepted access turns into exactly one kind of request
  a_one_kind: assert property (@(posedge cfg_avmm_clk) disable iff (!rst_n)
    (accept_wr || accept_rd) |=> (csr_req.write ^ csr_req.read));

endmodule

//--- source/aib_avmm_rsp_merge.sv
`timescale 1ns/1ps

module aib_avmm_rsp_merge
  import aib_avmm_pkg::*;
(
  input  logic        cfg_avmm_clk,
  input  logic        rst_n,
  input  csr_rsp_t    adapt_rsp,
  input  csr_rsp_t    aibio_rsp,
  output logic [31:0] cfg_avmm_rdata,
  output logic        cfg_avmm_rdatavld
);

  logic        rsp_valid;
  logic [31:0] rsp_data;

  assign rsp_valid = adapt_rsp.valid | aibio_rsp.valid; // both see every read

  // zero for unmapped words in the window
  assign rsp_data = adapt_rsp.hit ? adapt_rsp.data :
                    aibio_rsp.hit ? aibio_rsp.data : 32'h0;

  always_ff @(posedge cfg_avmm_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_avmm_rdatavld <= 1'b0;
      cfg_avmm_rdata    <= 32'h0;
    end else begin
      cfg_avmm_rdatavld <= rsp_valid;               // single cycle pulse
      if (rsp_valid) cfg_avmm_rdata <= rsp_data;    // hold between reads
    end
  end

  //////////////////////////////////////////////////
  // bank agreement
  //////////////////////////////////////////////////
  a_valid_agree: assert property (@(posedge cfg_avmm_clk) disable iff (!rst_n)
    adapt_rsp.valid == aibio_rsp.valid);

  a_one_hit: assert property (@(posedge cfg_avmm_clk) disable iff (!rst_n)
    !(adapt_rsp.hit && aibio_rsp.hit));

endmodule

//--- tests/tb_aib_avmm.sv
`timescale 1ns/1ps
`include "aib_avmm_defs.svh"

module tb_aib_avmm
  import aib_avmm_pkg::*;
();

  localparam int         N_ACC       = 600;
  localparam int         WATCHDOG_NS = (N_ACC + 200) * 8;  // accesses plus reset and drain
  localparam logic [5:0] CHAN_ID     = 6'h15;

  logic        clk;
  logic        rst_n;
  logic [5:0]  cfg_avmm_addr_id;
  logic        cfg_avmm_write;
  logic        cfg_avmm_read;
  logic [16:0] cfg_avmm_addr;
  logic [31:0] cfg_avmm_wdata;
  logic [3:0]  cfg_avmm_byte_en;
  logic [31:0] cfg_avmm_rdata;
  logic        cfg_avmm_rdatavld;
  logic        cfg_avmm_waitreq;
  adapt_cfg_t  adapt_cfg;
  aibio_cfg_t  aibio_cfg;
  logic [31:0] inbox_msg;
  logic        inbox_load;
  logic        outbox_send;
  logic        inbox_new_msg;
  int          err_count;
  int          check_count;
  int          pending_reads;
  logic [31:0] lcg_state;

  tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

  aib_avmm UUT (
    .cfg_avmm_clk(clk), .rst_n(rst_n), .cfg_avmm_addr_id(cfg_avmm_addr_id),
    .cfg_avmm_write(cfg_avmm_write), .cfg_avmm_read(cfg_avmm_read),
    .cfg_avmm_addr(cfg_avmm_addr), .cfg_avmm_wdata(cfg_avmm_wdata),
    .cfg_avmm_byte_en(cfg_avmm_byte_en), .cfg_avmm_rdata(cfg_avmm_rdata),
    .cfg_avmm_rdatavld(cfg_avmm_rdatavld), .cfg_avmm_waitreq(cfg_avmm_waitreq),
    .adapt_cfg(adapt_cfg), .aibio_cfg(aibio_cfg), .inbox_msg(inbox_msg),
    .inbox_load(inbox_load), .outbox_send(outbox_send), .inbox_new_msg(inbox_new_msg)
  );

  tb_checker chk (.*, .err_count(err_count), .check_count(check_count),
                  .pending_reads(pending_reads));

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // one access per call, driven after a falling edge
  //////////////////////////////////////////////////
  task automatic drive_random_access();
    logic [31:0] r0, r1, r2;
    logic [6:0]  idx;
    logic [10:0] off;
    logic [5:0]  id;
    r0 = rand32();
    r1 = rand32();
    r2 = rand32();
    idx = {3'b000, r0[25], 1'b0, r0[24:23]};             // 0..3 or 8..11
    if (r0[28:26] == 3'd0) idx = r0[22:16];              // any word, mostly unmapped
    off = {2'b01, idx, r0[15:14]};                       // inside window
    if (r0[13:11] == 3'd0) off = {r1[31], 1'b0, r1[30:22]}; // below or above window
    id = CHAN_ID;
    if (r0[10:8] == 3'd0) id = CHAN_ID ^ {r1[20:16], 1'b1};  // never matches
    cfg_avmm_read    = (r0[31:29] < 3'd3);
    cfg_avmm_write   = (r0[31:29] >= 3'd3) && (r0[31:29] < 3'd6);
    cfg_avmm_addr    = {id, off};
    cfg_avmm_wdata   = r2;
    cfg_avmm_byte_en = r1[11:8];
    inbox_load       = (r1[24:21] == 4'd0);
    inbox_msg        = {r2[15:0], r2[31:16]};
  endtask

  initial begin
    int errs_total;
    lcg_state        = 32'h5070_a1ef;
    cfg_avmm_addr_id = CHAN_ID;
    cfg_avmm_write   = 1'b0;
    cfg_avmm_read    = 1'b0;
    cfg_avmm_addr    = 17'h0;
    cfg_avmm_wdata   = 32'h0;
    cfg_avmm_byte_en = 4'h0;
    inbox_msg        = 32'h0;
    inbox_load       = 1'b0;
    wait (rst_n == 1'b1);
    @(negedge clk);
    while (cfg_avmm_waitreq) @(negedge clk);
    repeat (N_ACC) begin
      drive_random_access();
      @(negedge clk);
    end
    cfg_avmm_write = 1'b0;
    cfg_avmm_read  = 1'b0;
    inbox_load     = 1'b0;
    repeat (6) @(negedge clk);                           // last read lands 3 cycles on
    errs_total = err_count;
    if (pending_reads != 0) begin
      $display("%0d accepted reads never returned rdatavld", pending_reads);
      errs_total = errs_total + 1;
    end
    $display("checks: %0d  errors: %0d", check_count, errs_total);
    if (errs_total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the access sequence completed");
    $display("Test failed");
    $finish;
  end

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/1ps
`include "aib_avmm_defs.svh"

module tb_checker
  import aib_avmm_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [5:0]  cfg_avmm_addr_id,
  input  logic        cfg_avmm_write,
  input  logic        cfg_avmm_read,
  input  logic [16:0] cfg_avmm_addr,
  input  logic [31:0] cfg_avmm_wdata,
  input  logic [3:0]  cfg_avmm_byte_en,
  input  logic [31:0] cfg_avmm_rdata,
  input  logic        cfg_avmm_rdatavld,
  input  logic        cfg_avmm_waitreq,
  input  adapt_cfg_t  adapt_cfg,
  input  aibio_cfg_t  aibio_cfg,
  input  logic [31:0] inbox_msg,
  input  logic        inbox_load,
  input  logic        outbox_send,
  input  logic        inbox_new_msg,
  output int          err_count,
  output int          check_count,
  output int          pending_reads
);

  int          errs = 0;
  int          checks = 0;
  int          pend = 0;
  logic        rst_seen = 1'b0;    // first reset edge may precede the async clear
  logic [31:0] m_adapt [4];        // rx_0, rx_1, tx_0, tx_1
  logic [31:0] m_ifctl, m_rstctl, m_outbox, m_inbox;
  logic        m_new_msg, m_send, m_waitreq;
  logic        m_rsp_vld, m_vld;   // bank stage, combiner stage
  logic        q_wr, q_rd;         // front end stage
  logic [6:0]  q_idx;
  logic [31:0] q_wdata;
  logic [3:0]  q_be;
  logic [31:0] exp_q [$];          // read data in flight, in order

  assign err_count     = errs;
  assign check_count   = checks;
  assign pending_reads = pend;

  function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                              input logic [31:0] nxt,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (cur & ~mask) | (nxt & mask);
  endfunction

  function automatic logic [31:0] read_word(input logic [6:0] idx);
    if (idx < 7'd4) return m_adapt[idx[1:0]];
    case (idx)
      `IFCTL_IDX:  return m_ifctl;
      `RSTCTL_IDX: return m_rstctl;
      `OUTBOX_IDX: return m_outbox;
      `INBOX_IDX:  return m_inbox;
      default:     return 32'h0;   // unmapped word in window
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errs++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errs++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // model
  //////////////////////////////////////////////////
  task automatic reset_model();
    foreach (m_adapt[i]) m_adapt[i] = `ADAPT_RST_VAL;
    m_ifctl   = `AIBIO_RST_VAL;
    m_rstctl  = `AIBIO_RST_VAL;
    m_outbox  = `AIBIO_RST_VAL;
    m_inbox   = `AIBIO_RST_VAL;
    m_new_msg = 1'b0;
    m_send    = 1'b0;
    m_waitreq = 1'b1;            // held one cycle past reset
    m_rsp_vld = 1'b0;
    m_vld     = 1'b0;
    q_wr      = 1'b0;
    q_rd      = 1'b0;
    exp_q.delete();
  endtask

  // outputs as they stand before this edge
  task automatic compare_outputs();
    check_bit("cfg_avmm_waitreq", cfg_avmm_waitreq, m_waitreq);
    check_bit("cfg_avmm_rdatavld", cfg_avmm_rdatavld, m_vld);
    if (cfg_avmm_rdatavld === 1'b1) begin
      if (exp_q.size() == 0) begin
        errs++;
        $display("rdatavld pulsed with no read outstanding at %0t", $time);
      end else begin
        check_word("cfg_avmm_rdata", cfg_avmm_rdata, exp_q.pop_front());
      end
    end
    check_word("adapt_cfg.rx_0", adapt_cfg.rx_0, m_adapt[0]);
    check_word("adapt_cfg.rx_1", adapt_cfg.rx_1, m_adapt[1]);
    check_word("adapt_cfg.tx_0", adapt_cfg.tx_0, m_adapt[2]);
    check_word("adapt_cfg.tx_1", adapt_cfg.tx_1, m_adapt[3]);
    check_word("aibio_cfg.ifctl", aibio_cfg.ifctl, m_ifctl);
    check_word("aibio_cfg.rstctl", aibio_cfg.rstctl, m_rstctl);
    check_word("aibio_cfg.outbox_msg", aibio_cfg.outbox_msg, m_outbox);
    check_bit("aibio_cfg.inbox_autoclear_dis", aibio_cfg.inbox_autoclear_dis, m_ifctl[0]);
    check_bit("outbox_send", outbox_send, m_send);
    check_bit("inbox_new_msg", inbox_new_msg, m_new_msg);
  endtask

  task automatic advance_model();
    logic acc;
    logic send_next;
    logic clear_flag;
    m_vld = m_rsp_vld;                                   // combiner stage
    m_rsp_vld = q_rd;                                    // bank stage
    if (q_rd) exp_q.push_back(read_word(q_idx));         // data before this edge's write
    send_next  = q_wr && (q_idx == `OUTBOX_IDX);         // every outbox write sends
    clear_flag = q_rd && (q_idx == `INBOX_IDX) && !m_ifctl[0];
    if (q_wr) begin
      if (q_idx < 7'd4) m_adapt[q_idx[1:0]] = merge_bytes(m_adapt[q_idx[1:0]], q_wdata, q_be);
      else if (q_idx == `IFCTL_IDX) m_ifctl = merge_bytes(m_ifctl, q_wdata, q_be);
      else if (q_idx == `RSTCTL_IDX) m_rstctl = merge_bytes(m_rstctl, q_wdata, q_be);
      else if (q_idx == `OUTBOX_IDX) m_outbox = merge_bytes(m_outbox, q_wdata, q_be);
    end
    m_send = send_next;
    if (inbox_load) begin
      m_inbox   = inbox_msg;
      m_new_msg = 1'b1;                                  // load beats clear
    end else if (clear_flag) begin
      m_new_msg = 1'b0;
    end
    // front end stage, id and window decode
    acc = (cfg_avmm_read || cfg_avmm_write) && !m_waitreq
          && (cfg_avmm_addr[16:11] == cfg_avmm_addr_id)
          && (cfg_avmm_addr[10:0] >= `AIB_BASE_BOT) && (cfg_avmm_addr[10:0] < `AIB_BASE_TOP);
    q_wr    = acc && cfg_avmm_write;
    q_rd    = acc && cfg_avmm_read;
    q_idx   = cfg_avmm_addr[8:2];
    q_wdata = cfg_avmm_wdata;
    q_be    = cfg_avmm_byte_en;
    m_waitreq = 1'b0;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_model();
      if (rst_seen) compare_outputs(); // reset values on every later reset edge
      rst_seen = 1'b1;
    end else begin
      compare_outputs();
      advance_model();
    end
    pend = exp_q.size();
  end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_NS    = 4,  // 8 ns period
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
